// ==== design/beam_consts.svh ====
// ------------------------------
// beamformer size constants
// lane, channel and sample widths
// weight width and fraction bits
// product and lane sum widths
// ------------------------------

`ifndef BEAM_CONSTS_SVH
`define BEAM_CONSTS_SVH

// complex samples carried per beat on each channel
`define BEAM_LANES 8
// antenna channels combined into one beam
`define BEAM_CHANNELS 4
// width of one real or imaginary sample part
`define BEAM_SAMPLE_W 16
// width of one real or imaginary weight part
`define BEAM_WEIGHT_W 8
// the weight is Q1.7, so 127 is just under unity gain
`define BEAM_WEIGHT_FRAC 7
// sample times weight needs the sum of both widths
`define BEAM_PROD_W 24
// four 16-bit terms need two bits of growth before the wrap
`define BEAM_SUM_W 18
// index width for picking one of the channels
`define BEAM_CH_SEL_W 2

`endif

// ==== design/beam_pkg.sv ====
// ------------------------------
// beamformer shared types
// sample, beat and weight types
// per-beat control struct
// ------------------------------

`include "beam_consts.svh"

package beam_pkg;

    // one signed real or imaginary sample part
    typedef logic signed [`BEAM_SAMPLE_W-1:0] sample_t;

    // one complex sample with re in the upper half of the 32 bits
    typedef struct packed {
        sample_t re;
        sample_t im;
    } cplx_sample_t;

    // one channel's beat and also the combined output beam
    typedef cplx_sample_t [`BEAM_LANES-1:0] beat_t;

    // every channel's beat taken together on one strobe
    typedef beat_t [`BEAM_CHANNELS-1:0] array_beat_t;

    // one signed real or imaginary weight part
    typedef logic signed [`BEAM_WEIGHT_W-1:0] weight_t;

    // one complex weight applied to a whole channel
    typedef struct packed {
        weight_t re;
        weight_t im;
    } cplx_weight_t;

    // the weights of all channels indexed by channel number
    typedef cplx_weight_t [`BEAM_CHANNELS-1:0] weight_set_t;

    // control that moves beside the data through every pipeline stage
    // last marks the final beat of a frame and only counts while valid is high
    typedef struct packed {
        logic valid;
        logic last;
    } beat_ctl_t;

endpackage

// ==== design/beam_weight_regs.sv ====
// ------------------------------
// channel weight register block
// one complex weight per channel
// written by a select and strobe
// ------------------------------

`timescale 1ns/1ns

`include "beam_consts.svh"

module beam_weight_regs (
    input  logic                       clock,
    input  logic                       resetn,
    // write strobe that sets one entry per cycle
    input  logic                       weight_we,
    input  logic [`BEAM_CH_SEL_W-1:0]  weight_sel,
    input  beam_pkg::cplx_weight_t     weight_value,
    // all weights as read by the weighting stage
    output beam_pkg::weight_set_t      weights
);

    // the register block is small enough to live as a flat set of flops
    // next to the multipliers, so the weighting stage sees every entry at once
    //
    // a zero weight mutes its channel, so after reset the beam output is zero
    // until software loads a set of weights
    //
    // the write lands at the edge that samples weight_we, and the weighting
    // stage reads the stored value at the next edge, so a beat sampled one
    // cycle after the write already uses the new weight
    always_ff @(posedge clock) begin
        if (!resetn) begin
            weights <= '0;
        end else if (weight_we) begin
            // only the selected channel changes while the others keep their value
            weights[weight_sel] <= weight_value;
        end
    end

endmodule

// ==== design/beam_weighting_stage.sv ====
// ------------------------------
// complex weighting stage
// stage 1 forms the four products
// stage 2 scales and combines them
// control follows the data
// ------------------------------

`timescale 1ns/1ns

`include "beam_consts.svh"

module beam_weighting_stage (
    input  logic                   clock,
    input  logic                   resetn,
    // beat from the source that is taken whenever valid is high
    input  beam_pkg::beat_ctl_t    in_ctl,
    input  beam_pkg::array_beat_t  in_data,
    // current channel weights from the register block
    input  beam_pkg::weight_set_t  weights,
    // weighted beat two cycles behind the input
    output beam_pkg::beat_ctl_t    weighted_ctl,
    output beam_pkg::array_beat_t  weighted_data
);

    // full-width partial products of stage 1
    // rr = xr*wr, ii = xi*wi, ri = xr*wi, ir = xi*wr
    logic signed [`BEAM_PROD_W-1:0] prod_rr [`BEAM_CHANNELS][`BEAM_LANES];
    logic signed [`BEAM_PROD_W-1:0] prod_ii [`BEAM_CHANNELS][`BEAM_LANES];
    logic signed [`BEAM_PROD_W-1:0] prod_ri [`BEAM_CHANNELS][`BEAM_LANES];
    logic signed [`BEAM_PROD_W-1:0] prod_ir [`BEAM_CHANNELS][`BEAM_LANES];

    // control that belongs to the products held in stage 1
    beam_pkg::beat_ctl_t s1_ctl;

    // scaled and combined result, registered by stage 2
    beam_pkg::array_beat_t next_weighted;

    // removes the weight's fraction bits and keeps the low sample width
    // the arithmetic shift keeps the sign, the cast then wraps to 16 bits
    function automatic beam_pkg::sample_t scale_product(
        input logic signed [`BEAM_PROD_W-1:0] prod
    );
        return beam_pkg::sample_t'(prod >>> `BEAM_WEIGHT_FRAC);
    endfunction

    // valid and last move one register per stage, in step with the data
    always_ff @(posedge clock) begin
        if (!resetn) begin
            s1_ctl       <= '0;
            weighted_ctl <= '0;
        end else begin
            s1_ctl       <= in_ctl;
            weighted_ctl <= s1_ctl;
        end
    end

    // stage 1 multiplies every lane of every channel by that channel's weight
    // the weights are read at the same edge that samples the beat
    // both operands are signed, so the product is sign extended to 24 bits
    always_ff @(posedge clock) begin
        if (in_ctl.valid) begin
            for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
                for (int ln = 0; ln < `BEAM_LANES; ln++) begin
                    prod_rr[ch][ln] <= in_data[ch][ln].re * weights[ch].re;
                    prod_ii[ch][ln] <= in_data[ch][ln].im * weights[ch].im;
                    prod_ri[ch][ln] <= in_data[ch][ln].re * weights[ch].im;
                    prod_ir[ch][ln] <= in_data[ch][ln].im * weights[ch].re;
                end
            end
        end
    end

    // each product is scaled on its own before the add or subtract
    // real = rr - ii and imag = ri + ir, each wrapped to the sample width
    always_comb begin
        for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
            for (int ln = 0; ln < `BEAM_LANES; ln++) begin
                next_weighted[ch][ln].re = scale_product(prod_rr[ch][ln])
                                         - scale_product(prod_ii[ch][ln]);
                next_weighted[ch][ln].im = scale_product(prod_ri[ch][ln])
                                         + scale_product(prod_ir[ch][ln]);
            end
        end
    end

    // stage 2 only loads when stage 1 holds a valid beat
    // in a gap the old value stays while weighted_ctl.valid is low
    always_ff @(posedge clock) begin
        if (s1_ctl.valid) begin
            weighted_data <= next_weighted;
        end
    end

endmodule

// ==== design/beam_summer.sv ====
// ------------------------------
// beam summer
// adds the weighted channels
// per lane into one output beam
// ------------------------------

`timescale 1ns/1ns

`include "beam_consts.svh"

module beam_summer (
    input  logic                   clock,
    input  logic                   resetn,
    // weighted beat of every channel
    input  beam_pkg::beat_ctl_t    weighted_ctl,
    input  beam_pkg::array_beat_t  weighted_data,
    // combined beam one cycle behind the weighted beat
    output beam_pkg::beat_ctl_t    out_ctl,
    output beam_pkg::beat_t        out_data
);

    // lane sums with two guard bits, so the four-term add itself cannot overflow
    logic signed [`BEAM_SUM_W-1:0] sum_re [`BEAM_LANES];
    logic signed [`BEAM_SUM_W-1:0] sum_im [`BEAM_LANES];

    // the samples are signed, so each term is sign extended into the sum width
    always_comb begin
        for (int ln = 0; ln < `BEAM_LANES; ln++) begin
            sum_re[ln] = '0;
            sum_im[ln] = '0;
            for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
                sum_re[ln] = sum_re[ln] + weighted_data[ch][ln].re;
                sum_im[ln] = sum_im[ln] + weighted_data[ch][ln].im;
            end
        end
    end

    // output control is cleared on reset so no beat leaves before the first input
    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_ctl <= '0;
        end else begin
            out_ctl <= weighted_ctl;
        end
    end

    // only the low sample width is kept, so a large sum wraps around
    // the data only loads on a valid beat and is don't-care in gaps
    always_ff @(posedge clock) begin
        if (weighted_ctl.valid) begin
            for (int ln = 0; ln < `BEAM_LANES; ln++) begin
                out_data[ln].re <= sum_re[ln][`BEAM_SAMPLE_W-1:0];
                out_data[ln].im <= sum_im[ln][`BEAM_SAMPLE_W-1:0];
            end
        end
    end

endmodule

// ==== design/beam_combiner_top.sv ====
// ------------------------------
// beamformer top level
// weight registers, weighting
// stage and summer in a chain
// ------------------------------

`timescale 1ns/1ns

`include "beam_consts.svh"

module beam_combiner_top (
    input  logic                       clock,
    input  logic                       resetn,
    // four-channel beat with no ready, so every valid beat is taken
    input  beam_pkg::beat_ctl_t        in_ctl,
    input  beam_pkg::array_beat_t      in_data,
    // weight write port
    input  logic                       weight_we,
    input  logic [`BEAM_CH_SEL_W-1:0]  weight_sel,
    input  beam_pkg::cplx_weight_t     weight_value,
    // combined beam three cycles behind the input beat
    output beam_pkg::beat_ctl_t        out_ctl,
    output beam_pkg::beat_t            out_data
);

    // stored weights of every channel
    beam_pkg::weight_set_t weights;

    // weighted channels on their way to the summer
    beam_pkg::beat_ctl_t   weighted_ctl;
    beam_pkg::array_beat_t weighted_data;

    // register block, written by the control side
    beam_weight_regs beam_weight_regs_inst (
        .clock        (clock),
        .resetn       (resetn),
        .weight_we    (weight_we),
        .weight_sel   (weight_sel),
        .weight_value (weight_value),
        .weights      (weights)
    );

    // two cycles of complex multiply, scale and combine per channel
    beam_weighting_stage beam_weighting_stage_inst (
        .clock         (clock),
        .resetn        (resetn),
        .in_ctl        (in_ctl),
        .in_data       (in_data),
        .weights       (weights),
        .weighted_ctl  (weighted_ctl),
        .weighted_data (weighted_data)
    );

    // one cycle of per-lane summing across the channels
    beam_summer beam_summer_inst (
        .clock         (clock),
        .resetn        (resetn),
        .weighted_ctl  (weighted_ctl),
        .weighted_data (weighted_data),
        .out_ctl       (out_ctl),
        .out_data      (out_data)
    );

endmodule

// ==== verification/beam_model.svh ====
// ------------------------------
// beamformer reference model
// expected beam record and queue
// complex weighting of one sample
// four-channel lane sum
// ------------------------------

`ifndef BEAM_MODEL_SVH
`define BEAM_MODEL_SVH

`include "beam_consts.svh"

// one expected output beam together with the last flag of its input beat
typedef struct packed {
    beam_pkg::beat_t data;
    logic            last;
} expected_beam_t;

// beams still on their way through the DUT in order from the oldest
expected_beam_t expected_q [$];

// the weights the testbench wrote last as the DUT should hold them
beam_pkg::weight_set_t model_weights;

// multiplies at full width, drops the weight's fraction bits with sign kept
// and then keeps the low 16 bits
function automatic beam_pkg::sample_t drop_fraction(
    input logic signed [31:0] x,
    input logic signed [31:0] w
);
    logic signed [31:0] prod;
    logic signed [31:0] shifted;
    prod = x * w;
    shifted = prod >>> `BEAM_WEIGHT_FRAC;
    return shifted[`BEAM_SAMPLE_W-1:0];
endfunction

// one complex sample times one complex weight with each step wrapped to 16 bits
function automatic beam_pkg::cplx_sample_t weigh_sample(
    input beam_pkg::cplx_sample_t x,
    input beam_pkg::cplx_weight_t w
);
    logic signed [31:0] re_full;
    logic signed [31:0] im_full;
    beam_pkg::cplx_sample_t y;
    // real part is xr*wr - xi*wi and imaginary part is xr*wi + xi*wr
    re_full = drop_fraction(x.re, w.re) - drop_fraction(x.im, w.im);
    im_full = drop_fraction(x.re, w.im) + drop_fraction(x.im, w.re);
    y.re = re_full[`BEAM_SAMPLE_W-1:0];
    y.im = im_full[`BEAM_SAMPLE_W-1:0];
    return y;
endfunction

// the beam for one input beat with every lane summed over the four channels
function automatic beam_pkg::beat_t model_beam(
    input beam_pkg::array_beat_t beat,
    input beam_pkg::weight_set_t weights
);
    logic signed [31:0] acc_re;
    logic signed [31:0] acc_im;
    beam_pkg::cplx_sample_t term;
    beam_pkg::beat_t beam;
    for (int ln = 0; ln < `BEAM_LANES; ln++) begin
        acc_re = 0;
        acc_im = 0;
        for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
            term = weigh_sample(beat[ch][ln], weights[ch]);
            acc_re = acc_re + term.re;
            acc_im = acc_im + term.im;
        end
        // the sum wraps since only the low sample width leaves the DUT
        beam[ln].re = acc_re[`BEAM_SAMPLE_W-1:0];
        beam[ln].im = acc_im[`BEAM_SAMPLE_W-1:0];
    end
    return beam;
endfunction

// queues the beam that a beat driven now must produce three cycles later
task automatic push_expected(input beam_pkg::array_beat_t beat, input logic last);
    expected_beam_t entry;
    entry.data = model_beam(beat, model_weights);
    entry.last = last;
    expected_q.push_back(entry);
endtask

`endif

// ==== verification/beam_combiner_tb.sv ====
// ------------------------------
// beamformer testbench
// clock, reset and random beats
// weight writes and model checks
// cycle timeout and summary
// ------------------------------

`timescale 1ns/1ns

`include "beam_consts.svh"

module beam_combiner_tb;

    // per-test worst case in cycles with the drain included
    // after_reset, single_channel, all_channels, last_flag, weight_change, wraparound
    localparam int TEST_CYCLES = 30 + 80 + 430 + 140 + 140 + 70;
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 100;

    logic                       clock;
    logic                       resetn;
    beam_pkg::beat_ctl_t        in_ctl;
    beam_pkg::array_beat_t      in_data;
    logic                       weight_we;
    logic [`BEAM_CH_SEL_W-1:0]  weight_sel;
    beam_pkg::cplx_weight_t     weight_value;
    beam_pkg::beat_ctl_t        out_ctl;
    beam_pkg::beat_t            out_data;

    int    seed;
    int    cycle_count = 0;
    string test_name = "reset";
    int    test_driven = 0;
    int    test_checked = 0;
    int    test_errors = 0;
    int    total_checked = 0;
    int    total_errors = 0;
    int    tests_run = 0;

    `include "beam_model.svh"

    beam_combiner_top beam_combiner_top_inst (
        .clock        (clock),
        .resetn       (resetn),
        .in_ctl       (in_ctl),
        .in_data      (in_data),
        .weight_we    (weight_we),
        .weight_sel   (weight_sel),
        .weight_value (weight_value),
        .out_ctl      (out_ctl),
        .out_data     (out_data)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // guards against a stuck run whatever the tests are doing
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    // outputs change just after the rising edge, so they are read on the falling one
    // a valid that is not cleanly low counts as an output beat
    always @(negedge clock) begin
        expected_beam_t exp;
        if (resetn && out_ctl.valid !== 1'b0) begin
            if (expected_q.size() == 0) begin
                $display("test %s: output valid is not low although no beat was waiting",
                         test_name);
                test_errors++;
            end else begin
                exp = expected_q.pop_front();
                test_checked++;
                assert (out_data === exp.data) else begin
                    $display("CHECK FAILED %s data expected %h actual %h",
                             test_name, exp.data, out_data);
                    test_errors++;
                end
                assert (out_ctl.last === exp.last) else begin
                    $display("CHECK FAILED %s last expected %b actual %b",
                             test_name, exp.last, out_ctl.last);
                    test_errors++;
                end
            end
        end
    end

    // every driver waits for the edge, then changes the inputs 2 ns later
    task automatic drive_idle();
        @(posedge clock);
        #2;
        in_ctl = '0;
        weight_we = 1'b0;
    endtask

    task automatic drive_beat(input beam_pkg::array_beat_t beat, input logic last);
        @(posedge clock);
        #2;
        in_ctl = '{valid: 1'b1, last: last};
        in_data = beat;
        weight_we = 1'b0;
        push_expected(beat, last);
        test_driven++;
    endtask

    // the input stays idle in the write cycle
    task automatic write_weight(input int sel, input beam_pkg::cplx_weight_t value);
        @(posedge clock);
        #2;
        in_ctl = '0;
        weight_we = 1'b1;
        weight_sel = sel[`BEAM_CH_SEL_W-1:0];
        weight_value = value;
        model_weights[sel] = value;
    endtask

    // extreme picks only the end points of the signed range
    function automatic beam_pkg::cplx_weight_t random_weight(input logic extreme);
        logic [31:0] r;
        beam_pkg::cplx_weight_t w;
        r = $random(seed);
        w.re = extreme ? (r[0] ? 8'h7f : 8'h80) : r[7:0];
        w.im = extreme ? (r[1] ? 8'h7f : 8'h80) : r[15:8];
        return w;
    endfunction

    function automatic beam_pkg::array_beat_t random_beat(input logic extreme);
        logic [31:0] r;
        beam_pkg::array_beat_t beat;
        for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
            for (int ln = 0; ln < `BEAM_LANES; ln++) begin
                r = $random(seed);
                beat[ch][ln].re = extreme ? (r[0] ? 16'h7fff : 16'h8000) : r[15:0];
                beat[ch][ln].im = extreme ? (r[1] ? 16'h7fff : 16'h8000) : r[31:16];
            end
        end
        return beat;
    endfunction

    function automatic logic random_last();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    // pipeline depth is 3, so 8 idle cycles is plenty for the last beat to leave
    task automatic finish_test();
        int waited;
        waited = 0;
        while (expected_q.size() != 0 && waited < 8) begin
            drive_idle();
            waited++;
        end
        if (expected_q.size() != 0) begin
            $display("test %s: %0d expected beats never came out", test_name, expected_q.size());
            test_errors++;
            expected_q.delete();
        end
        // a few more idle cycles so that a stray extra beat is still seen
        repeat (3) drive_idle();
        if (test_checked != test_driven) begin
            $display("test %s: %0d beats driven but %0d came out",
                     test_name, test_driven, test_checked);
            test_errors++;
        end
        $display("test %s: %0d beats, %0d checked, %0d errors",
                 test_name, test_driven, test_checked, test_errors);
        total_checked += test_checked;
        total_errors += test_errors;
        tests_run++;
        test_driven = 0;
        test_checked = 0;
        test_errors = 0;
    endtask

    initial begin
        seed = 32'hfb3c59ee;
        resetn = 1'b0;
        in_ctl = '0;
        in_data = '0;
        weight_we = 1'b0;
        weight_sel = '0;
        weight_value = '0;
        model_weights = '0;
        repeat (3) @(posedge clock);
        #2;
        resetn = 1'b1;

        // nothing driven and weights still zero, so no beat may appear
        test_name = "after_reset";
        repeat (10) drive_idle();
        finish_test();

        // only channel 0 contributes
        // channels 1 to 3 keep the zero weight they were given by reset
        test_name = "single_channel";
        write_weight(0, random_weight(1'b0));
        repeat (50) drive_beat(random_beat(1'b0), random_last());
        finish_test();

        // about one gap in four beats mixes back-to-back flight with idle cycles
        test_name = "all_channels";
        for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
            write_weight(ch, random_weight(1'b0));
        end
        for (int i = 0; i < 200; i++) begin
            if (($random(seed) & 3) == 0) begin
                drive_idle();
            end
            drive_beat(random_beat(1'b0), random_last());
        end
        finish_test();

        test_name = "last_flag";
        for (int i = 0; i < 60; i++) begin
            if (($random(seed) & 1) == 0) begin
                drive_idle();
            end
            drive_beat(random_beat(1'b0), random_last());
        end
        finish_test();

        // new weights while the previous burst is still inside the pipeline
        test_name = "weight_change";
        repeat (4) begin
            for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
                write_weight(ch, random_weight(1'b0));
            end
            drive_idle();
            repeat (20) drive_beat(random_beat(1'b0), random_last());
        end
        finish_test();

        test_name = "wraparound";
        for (int ch = 0; ch < `BEAM_CHANNELS; ch++) begin
            write_weight(ch, random_weight(1'b1));
        end
        repeat (40) drive_beat(random_beat(1'b1), random_last());
        finish_test();

        $display("summary: %0d tests, %0d beats checked, %0d errors",
                 tests_run, total_checked, total_errors);
        if (total_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+design
+incdir+verification
design/beam_pkg.sv
design/beam_weight_regs.sv
design/beam_weighting_stage.sv
design/beam_summer.sv
design/beam_combiner_top.sv
verification/beam_combiner_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the beamformer testbench with Verilator and run it.
# The result is decided by a search for the pass line in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module beam_combiner_tb \
    -o beam_combiner_sim

output=$(./obj_dir/beam_combiner_sim)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi
